/* design/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              imemWrEn,   // Boot load, only in reset
  input  logic [pipePkg::memAddrWidth-1:0]  imemAddr,
  input  logic [isaPkg::dataWidth-1:0]      imemData,
  output logic [isaPkg::dataWidth-1:0]      pc,
  output logic                              hlt,
  output logic                              wbEn,       // Register write-back report
  output logic [isaPkg::regAddrWidth-1:0]   wbAddr,
  output logic [isaPkg::dataWidth-1:0]      wbData
);

  logic [isaPkg::dataWidth-1:0] instr, pcPlusOne, redirectTarget;
  logic                         fetchValid, holdFetch, redirect;

  decExIf decEx ();
  exMemIf exMem ();

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  fetchUnit uFetch (
    .clk, .rstN, .imemWrEn, .imemAddr, .imemData,
    .holdFetch, .redirect, .redirectTarget,
    .pc, .instr, .pcPlusOne, .fetchValid
  );

  decodeStage uDecode (
    .clk, .rstN, .instr, .pcPlusOne, .fetchValid, .redirect,
    .wbEn, .wbAddr, .wbData,
    .decEx (decEx),
    .holdFetch
  );

  executeStage uExecute (
    .clk, .rstN, .wbEn, .wbAddr, .wbData,
    .decEx (decEx),
    .exMem (exMem),
    .redirect, .redirectTarget
  );

  memWriteback uMemWb (
    .clk, .rstN,
    .exMem (exMem),
    .wbEn, .wbAddr, .wbData, .hlt
  );

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [isaPkg::dataWidth-1:0]      instr,
  input  logic [isaPkg::dataWidth-1:0]      pcPlusOne,
  input  logic                              fetchValid,
  input  logic                              redirect,
  input  logic                              wbEn,
  input  logic [isaPkg::regAddrWidth-1:0]   wbAddr,
  input  logic [isaPkg::dataWidth-1:0]      wbData,
  decExIf.source                            decEx,
  output logic                              holdFetch
);

  logic [isaPkg::dataWidth-1:0]    regFile [2**isaPkg::regAddrWidth];
  isaPkg::opcodeT                  op;
  isaPkg::condT                    cond;
  logic [isaPkg::regAddrWidth-1:0] rsAddr, rtAddr, rdAddr;
  logic [isaPkg::dataWidth-1:0]    rsData, rtData;
  logic [isaPkg::dataWidth-1:0]    immMem, immLlb, immBr, imm;
  logic                            regWrite, memRead, memWrite;
  logic                            usesRs, usesRt;
  logic                            loadUse, isHalt, bubble;

  // Field split
  assign op     = isaPkg::opcodeT'(instr[isaPkg::opLsb +: isaPkg::opWidth]);
  assign cond   = isaPkg::condT'(instr[isaPkg::condLsb +: isaPkg::condWidth]);
  assign rdAddr = instr[isaPkg::rdLsb +: isaPkg::regAddrWidth];
  assign rsAddr = instr[isaPkg::rsLsb +: isaPkg::regAddrWidth];
  // SW reads its data register from the Rd slot
  assign rtAddr = (op == isaPkg::SW) ? rdAddr : instr[isaPkg::rtLsb +: isaPkg::regAddrWidth];

  // Sign extension of each immediate form
  assign immMem = {{(isaPkg::dataWidth - isaPkg::memOffWidth){instr[isaPkg::memOffWidth-1]}},
                   instr[isaPkg::memOffWidth-1:0]};
  assign immLlb = {{(isaPkg::dataWidth - isaPkg::llbImmWidth){instr[isaPkg::llbImmWidth-1]}},
                   instr[isaPkg::llbImmWidth-1:0]};
  assign immBr  = {{(isaPkg::dataWidth - isaPkg::brOffWidth){instr[isaPkg::brOffWidth-1]}},
                   instr[isaPkg::brOffWidth-1:0]};

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    usesRs   = 1'b0;
    usesRt   = 1'b0;
    imm      = '0;
    case (op)
      isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::NOR: begin
        regWrite = 1'b1;
        usesRs   = 1'b1;
        usesRt   = 1'b1;
      end
      isaPkg::LLB: begin
        regWrite = 1'b1;
        imm      = immLlb;
      end
      isaPkg::LW: begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        usesRs   = 1'b1;
        imm      = immMem;
      end
      isaPkg::SW: begin
        memWrite = 1'b1;
        usesRs   = 1'b1;
        usesRt   = 1'b1;  // Store data
        imm      = immMem;
      end
      isaPkg::B:  imm = immBr;
      default: ;          // HLT and unused codes
    endcase
  end

  // Register file, written in write-back
  always_ff @(posedge clk) begin
    if (wbEn) begin
      regFile[wbAddr] <= wbData;
    end
  end

  // Write-through read
  assign rsData = (wbEn && wbAddr == rsAddr) ? wbData : regFile[rsAddr];
  assign rtData = (wbEn && wbAddr == rtAddr) ? wbData : regFile[rtAddr];

  // LW in execute feeding this instruction
  assign loadUse = fetchValid && decEx.valid && decEx.memRead &&
                   ((usesRs && rsAddr == decEx.rdAddr) || (usesRt && rtAddr == decEx.rdAddr));
  assign isHalt    = fetchValid && op == isaPkg::HLT;  // Freeze fetch behind HLT
  assign holdFetch = loadUse || isHalt;
  assign bubble    = !fetchValid || loadUse || redirect;

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decEx.valid    <= 1'b0;
      decEx.regWrite <= 1'b0;
      decEx.memRead  <= 1'b0;
      decEx.memWrite <= 1'b0;
    end else begin
      decEx.valid    <= !bubble;
      decEx.regWrite <= regWrite && !bubble;
      decEx.memRead  <= memRead && !bubble;
      decEx.memWrite <= memWrite && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    decEx.op        <= op;
    decEx.cond      <= cond;
    decEx.rsAddr    <= rsAddr;
    decEx.rtAddr    <= rtAddr;
    decEx.rdAddr    <= rdAddr;
    decEx.rsData    <= rsData;
    decEx.rtData    <= rtData;
    decEx.imm       <= imm;
    decEx.pcPlusOne <= pcPlusOne;
  end

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              wbEn,
  input  logic [isaPkg::regAddrWidth-1:0]   wbAddr,
  input  logic [isaPkg::dataWidth-1:0]      wbData,
  decExIf.sink                              decEx,
  exMemIf.source                            exMem,
  output logic                              redirect,
  output logic [isaPkg::dataWidth-1:0]      redirectTarget
);

  pipePkg::fwdSelT              fwdA, fwdB;
  logic [isaPkg::dataWidth-1:0] opA, rtVal, aluResult;
  pipePkg::flagsT               flagQ;
  logic                         ovf, setZnv, setZ, condMet, isHalt;

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////

  // EX/MEM is newer than write-back so it is checked first
  always_comb begin
    fwdA = pipePkg::FWD_REG;
    if (exMem.regWrite && exMem.rdAddr == decEx.rsAddr) fwdA = pipePkg::FWD_MEM;
    else if (wbEn && wbAddr == decEx.rsAddr)            fwdA = pipePkg::FWD_WB;
  end

  always_comb begin
    fwdB = pipePkg::FWD_REG;
    if (exMem.regWrite && exMem.rdAddr == decEx.rtAddr) fwdB = pipePkg::FWD_MEM;
    else if (wbEn && wbAddr == decEx.rtAddr)            fwdB = pipePkg::FWD_WB;
  end

  always_comb begin
    case (fwdA)
      pipePkg::FWD_MEM: opA = exMem.aluResult;
      pipePkg::FWD_WB:  opA = wbData;
      default:          opA = decEx.rsData;
    endcase
    case (fwdB)
      pipePkg::FWD_MEM: rtVal = exMem.aluResult;
      pipePkg::FWD_WB:  rtVal = wbData;
      default:          rtVal = decEx.rtData;
    endcase
  end

  // ALU
  always_comb begin
    aluResult = '0;
    ovf       = 1'b0;
    setZnv    = 1'b0;
    setZ      = 1'b0;
    case (decEx.op)
      isaPkg::ADD: begin
        aluResult = opA + rtVal;  // Wraps
        ovf       = (opA[15] == rtVal[15]) && (aluResult[15] != opA[15]);
        setZnv    = 1'b1;
      end
      isaPkg::SUB: begin
        aluResult = opA - rtVal;
        ovf       = (opA[15] != rtVal[15]) && (aluResult[15] != opA[15]);
        setZnv    = 1'b1;
      end
      isaPkg::AND: begin
        aluResult = opA & rtVal;
        setZ      = 1'b1;
      end
      isaPkg::NOR: begin
        aluResult = ~(opA | rtVal);
        setZ      = 1'b1;
      end
      isaPkg::LLB:         aluResult = decEx.imm;        // Pass immediate
      isaPkg::LW, isaPkg::SW: aluResult = opA + decEx.imm;  // Base plus offset
      default: ;
    endcase
  end

  // Flag register, N and V kept on logic ops
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagQ <= '0;
    end else if (decEx.valid && setZnv) begin
      flagQ <= '{z: (aluResult == '0), n: aluResult[15], v: ovf};
    end else if (decEx.valid && setZ) begin
      flagQ.z <= (aluResult == '0);
    end
  end

  // Branch condition
  always_comb begin
    case (decEx.cond)
      isaPkg::NE:  condMet = !flagQ.z;
      isaPkg::EQ:  condMet = flagQ.z;
      isaPkg::GT:  condMet = !flagQ.z && !flagQ.n;
      isaPkg::LT:  condMet = flagQ.n;
      isaPkg::GE:  condMet = flagQ.z || !flagQ.n;
      isaPkg::LE:  condMet = flagQ.n || flagQ.z;
      isaPkg::OVF: condMet = flagQ.v;
      default:     condMet = 1'b1;  // UNCOND
    endcase
  end

  assign redirect       = decEx.valid && decEx.op == isaPkg::B && condMet;
  assign redirectTarget = decEx.pcPlusOne + decEx.imm;
  assign isHalt         = decEx.valid && decEx.op == isaPkg::HLT;

  //////////////////////////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid    <= 1'b0;
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.halt     <= 1'b0;
    end else begin
      exMem.valid    <= decEx.valid;
      exMem.regWrite <= decEx.regWrite;  // Already cleared in bubbles
      exMem.memRead  <= decEx.memRead;
      exMem.memWrite <= decEx.memWrite;
      exMem.halt     <= isHalt;
    end
  end

  always_ff @(posedge clk) begin
    exMem.rdAddr    <= decEx.rdAddr;
    exMem.aluResult <= aluResult;
    exMem.storeData <= rtVal;  // Forwarded store data
  end

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              imemWrEn,
  input  logic [pipePkg::memAddrWidth-1:0]  imemAddr,
  input  logic [isaPkg::dataWidth-1:0]      imemData,
  input  logic                              holdFetch,       // Stall or halt from decode
  input  logic                              redirect,        // Taken branch in execute
  input  logic [isaPkg::dataWidth-1:0]      redirectTarget,
  output logic [isaPkg::dataWidth-1:0]      pc,
  output logic [isaPkg::dataWidth-1:0]      instr,
  output logic [isaPkg::dataWidth-1:0]      pcPlusOne,
  output logic                              fetchValid
);

  logic [isaPkg::dataWidth-1:0] imem [pipePkg::imemDepth];
  logic [isaPkg::dataWidth-1:0] fetchWord;
  logic [isaPkg::dataWidth-1:0] pcInc;

  assign fetchWord = imem[pc[pipePkg::memAddrWidth-1:0]];  // Async read at pc
  assign pcInc     = pc + 1'b1;

  // Boot port, live only while held in reset
  always_ff @(posedge clk) begin
    if (!rstN && imemWrEn) begin
      imem[imemAddr] <= imemData;
    end
  end

  // Program counter
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectTarget;  // Branch wins over hold
    end else if (!holdFetch) begin
      pc <= pcInc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchValid <= 1'b0;
    end else if (redirect) begin
      fetchValid <= 1'b0;  // Flush wrong-path fetch
    end else if (!holdFetch) begin
      fetchValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!holdFetch) begin
      instr     <= fetchWord;
      pcPlusOne <= pcInc;
    end
  end

endmodule

/* design/isaPkg.sv */
package isaPkg;

  // Word and register file geometry
  localparam int dataWidth    = 16;
  localparam int regAddrWidth = 4;

  // Instruction field positions
  localparam int opWidth     = 4;
  localparam int opLsb       = 12;  // Opcode in 15..12
  localparam int rdLsb       = 8;   // Rd, also Rt for LW/SW
  localparam int rsLsb       = 4;
  localparam int rtLsb       = 0;
  localparam int memOffWidth = 4;   // LW/SW offset in 3..0
  localparam int llbImmWidth = 8;   // LLB byte in 7..0
  localparam int condLsb     = 9;   // Branch condition in 11..9
  localparam int condWidth   = 3;
  localparam int brOffWidth  = 9;   // Branch offset in 8..0

  // Unlisted codes fall through as no-ops
  typedef enum logic [opWidth-1:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    NOR = 4'd3,
    LW  = 4'd8,
    SW  = 4'd9,
    LLB = 4'd10,
    B   = 4'd12,
    HLT = 4'd15
  } opcodeT;

  typedef enum logic [condWidth-1:0] {
    NE, EQ, GT, LT, GE, LE, OVF, UNCOND
  } condT;

endpackage

/* design/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback (
  input  logic                              clk,
  input  logic                              rstN,
  exMemIf.sink                              exMem,
  output logic                              wbEn,
  output logic [isaPkg::regAddrWidth-1:0]   wbAddr,
  output logic [isaPkg::dataWidth-1:0]      wbData,
  output logic                              hlt
);

  logic [isaPkg::dataWidth-1:0]     dmem [pipePkg::dmemDepth];
  logic [pipePkg::memAddrWidth-1:0] memAddr;
  logic [isaPkg::dataWidth-1:0]     loadData;

  // Word address from low bits of the ALU sum
  assign memAddr  = exMem.aluResult[pipePkg::memAddrWidth-1:0];
  assign loadData = dmem[memAddr];  // Async read for LW

  //////////////////////////////////////////////////////////////////////
  // Data memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memWrite) begin
      dmem[memAddr] <= exMem.storeData;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////////////////////////

  // One strobe per retiring register writer
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= exMem.valid && exMem.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbAddr <= exMem.rdAddr;
    wbData <= exMem.memRead ? loadData : exMem.aluResult;
  end

  // Sticky halt, cleared only by reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      hlt <= 1'b0;
    end else if (exMem.valid && exMem.halt) begin
      hlt <= 1'b1;
    end
  end

endmodule

/* design/pipeIf.sv */
`timescale 1ns/1ps

// Decode to execute register
interface decExIf;
  logic                            valid;
  isaPkg::opcodeT                  op;
  logic [isaPkg::regAddrWidth-1:0] rsAddr, rtAddr, rdAddr;
  logic [isaPkg::dataWidth-1:0]    rsData, rtData;
  logic [isaPkg::dataWidth-1:0]    imm;        // Already sign-extended
  isaPkg::condT                    cond;
  logic [isaPkg::dataWidth-1:0]    pcPlusOne;
  logic                            regWrite, memRead, memWrite;

  modport source(output valid, op, rsAddr, rtAddr, rdAddr, rsData, rtData, imm, cond,
                        pcPlusOne, regWrite, memRead, memWrite);
  modport sink(input valid, op, rsAddr, rtAddr, rdAddr, rsData, rtData, imm, cond,
                     pcPlusOne, regWrite, memRead, memWrite);
endinterface

// Execute to memory register
interface exMemIf;
  logic                            valid;
  logic [isaPkg::regAddrWidth-1:0] rdAddr;
  logic                            regWrite, memRead, memWrite;
  logic                            halt;       // HLT on its way to write-back
  logic [isaPkg::dataWidth-1:0]    aluResult;  // Also the data address
  logic [isaPkg::dataWidth-1:0]    storeData;

  modport source(output valid, rdAddr, regWrite, memRead, memWrite, halt, aluResult, storeData);
  modport sink(input valid, rdAddr, regWrite, memRead, memWrite, halt, aluResult, storeData);
endinterface

/* design/pipePkg.sv */
package pipePkg;

  //////////////////////////////////////////////////////////////////////
  // Memory sizes
  //////////////////////////////////////////////////////////////////////

  localparam int memAddrWidth = 8;
  localparam int imemDepth    = 256;  // Words
  localparam int dmemDepth    = 256;

  //////////////////////////////////////////////////////////////////////
  // Execute stage types
  //////////////////////////////////////////////////////////////////////

  // Source of an ALU operand
  typedef enum logic [1:0] {
    FWD_REG,  // Value read in decode
    FWD_MEM,  // Result sitting in EX/MEM
    FWD_WB    // Value on the write-back port
  } fwdSelT;

  // Condition flags
  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

endpackage

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

  localparam int clkPeriod     = 10;
  localparam int numTests      = 5;
  localparam int cyclesPerTest = 300;  // Watchdog budget per test
  localparam int haltLimit     = 200;  // Cycles allowed from reset release to hlt
  localparam int haltHold      = 20;   // Cycles watched after hlt
  localparam logic [isaPkg::dataWidth-1:0] hltWord = {isaPkg::HLT, 12'h000};

  logic                              clk, rstN, imemWrEn;
  logic [pipePkg::memAddrWidth-1:0]  imemAddr;
  logic [isaPkg::dataWidth-1:0]      imemData, pc, wbData;
  logic                              hlt, wbEn;
  logic [isaPkg::regAddrWidth-1:0]   wbAddr;

  logic [isaPkg::dataWidth-1:0]      prog [$];     // Image for the next boot load
  logic [isaPkg::regAddrWidth-1:0]   expAddr [$];
  logic [isaPkg::dataWidth-1:0]      expData [$];
  logic [isaPkg::regAddrWidth-1:0]   gotAddr [$];  // Seen on the write-back port
  logic [isaPkg::dataWidth-1:0]      gotData [$];
  int                                errCount, failCount, testErrBase;

  cpuTop UUT (
    .clk, .rstN, .imemWrEn, .imemAddr, .imemData,
    .pc, .hlt, .wbEn, .wbAddr, .wbData
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction encoding
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] aluInstr(isaPkg::opcodeT op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  // Rt sits in the Rd slot for LW and SW
  function automatic logic [15:0] memInstr(isaPkg::opcodeT op, int rt, int rs, int off);
    return {op, 4'(rt), 4'(rs), 4'(off)};
  endfunction

  function automatic logic [15:0] llbInstr(int rd, logic [7:0] val);
    return {isaPkg::LLB, 4'(rd), val};
  endfunction

  function automatic logic [15:0] branchInstr(isaPkg::condT c, int off);
    return {isaPkg::B, c, 9'(off)};  // Target is pc + 1 + off
  endfunction

  function automatic logic [15:0] signExt8(logic [7:0] val);
    return {{8{val[7]}}, val};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Run and compare helpers
  //////////////////////////////////////////////////////////////////////

  task automatic expectWrite(int rd, logic [15:0] val);
    expAddr.push_back(4'(rd));
    expData.push_back(val);
  endtask

  // Boot load in reset, then collect write-backs until hlt
  task automatic runAndCheck(string name, output bit halted);
    int i;
    int cycles;
    rstN = 1'b0;  // Called on a falling edge
    repeat (5) @(negedge clk);
    for (i = 0; i < prog.size(); i++) begin
      imemWrEn = 1'b1;
      imemAddr = 8'(i);
      imemData = prog[i];
      @(negedge clk);
    end
    imemWrEn = 1'b0;
    rstN     = 1'b1;
    gotAddr.delete();
    gotData.delete();
    halted = 1'b0;
    cycles = 0;
    while (!halted && cycles < haltLimit) begin
      @(negedge clk);  // Registered outputs settled
      cycles++;
      if (wbEn) begin
        gotAddr.push_back(wbAddr);
        gotData.push_back(wbData);
      end
      halted = hlt;
    end
    if (!halted) begin
      $display("%s: hlt never rose within %0d cycles of reset release", name, haltLimit);
      errCount++;
    end
    if (gotAddr.size() != expAddr.size()) begin
      $display("ERR %0t: %s saw %0d write-backs, expected %0d", $time, name,
               gotAddr.size(), expAddr.size());
      errCount++;
    end
    for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
      if (gotAddr[i] !== expAddr[i] || gotData[i] !== expData[i]) begin
        $display("ERR %0t: %s write %0d expected r%0d=%h, got r%0d=%h", $time, name, i,
                 expAddr[i], expData[i], gotAddr[i], gotData[i]);
        errCount++;
      end
    end
  endtask

  task automatic finishTest(string name);
    if (errCount == testErrBase) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errCount - testErrBase);
      failCount++;
    end
    testErrBase = errCount;
    expAddr.delete();
    expData.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Dependent chain, every operand forwarded
  task automatic arithForwarding();
    logic [7:0]  a, b;
    logic [15:0] r1, r2, r3, r4, r5;
    bit          halted;
    a  = 8'($urandom());
    b  = 8'($urandom());
    r1 = signExt8(a);
    r2 = signExt8(b);
    r3 = r1 + r2;  // Wraps at 16 bits
    r4 = r3 - r1;
    r5 = r4 & r3;
    prog = {llbInstr(1, a), llbInstr(2, b), aluInstr(isaPkg::ADD, 3, 1, 2),
            aluInstr(isaPkg::SUB, 4, 3, 1), aluInstr(isaPkg::AND, 5, 4, 3),
            aluInstr(isaPkg::NOR, 6, 5, 2), hltWord};
    expectWrite(1, r1);
    expectWrite(2, r2);
    expectWrite(3, r3);
    expectWrite(4, r4);
    expectWrite(5, r5);
    expectWrite(6, ~(r5 | r2));
    runAndCheck("arithForwarding", halted);
    finishTest("arithForwarding");
  endtask

  // Store then load, plus an ADD right behind the LW
  task automatic memoryLoadUse();
    logic [7:0]  a, c;
    logic [15:0] sa, sc;
    bit          halted;
    a  = 8'($urandom());
    c  = 8'($urandom());
    sa = signExt8(a);
    sc = signExt8(c);
    prog = {llbInstr(1, a), llbInstr(2, 8'h10), memInstr(isaPkg::SW, 1, 2, 3),
            memInstr(isaPkg::LW, 3, 2, 3), aluInstr(isaPkg::ADD, 4, 3, 1),
            llbInstr(5, c), memInstr(isaPkg::SW, 5, 2, -1), memInstr(isaPkg::LW, 6, 2, -1),
            hltWord};
    expectWrite(1, sa);
    expectWrite(2, 16'h0010);  // Base word address
    expectWrite(3, sa);
    expectWrite(4, sa + sa);
    expectWrite(5, sc);
    expectWrite(6, sc);        // Negative offset, word 15
    runAndCheck("memoryLoadUse", halted);
    finishTest("memoryLoadUse");
  endtask

  // Skipped LLBs use r10..r13 and must never show up
  task automatic branchSkips();
    logic [7:0] m, f1, f2;
    bit         halted;
    m  = 8'($urandom());
    f1 = 8'($urandom());
    f2 = 8'($urandom());
    prog = {llbInstr(1, 8'd5), llbInstr(2, 8'd3), aluInstr(isaPkg::SUB, 3, 1, 2),
            branchInstr(isaPkg::GT, 2), llbInstr(10, m), llbInstr(11, m),
            aluInstr(isaPkg::SUB, 4, 2, 1), branchInstr(isaPkg::GE, 1), llbInstr(5, f1),
            branchInstr(isaPkg::LT, 1), llbInstr(12, m), aluInstr(isaPkg::SUB, 6, 1, 1),
            branchInstr(isaPkg::NE, 1), llbInstr(7, f2), branchInstr(isaPkg::UNCOND, 1),
            llbInstr(13, m), hltWord};
    expectWrite(1, 16'd5);
    expectWrite(2, 16'd3);
    expectWrite(3, 16'd2);     // Positive, GT taken
    expectWrite(4, 16'hFFFE);  // Negative, GE falls through
    expectWrite(5, signExt8(f1));
    expectWrite(6, 16'h0000);  // Zero, NE falls through
    expectWrite(7, signExt8(f2));
    runAndCheck("branchSkips", halted);
    finishTest("branchSkips");
  endtask

  task automatic flagEffects();
    logic [7:0]  x, m, f;
    logic [15:0] v;
    bit          halted;
    int          i;
    x = 8'h40 | 8'($urandom() & 32'h3F);  // Bit 6 set so doubling reaches bit 14
    m = 8'($urandom());
    f = 8'($urandom());
    v = signExt8(x);
    prog = {llbInstr(1, x)};
    expectWrite(1, v);
    for (i = 0; i < 8; i++) begin
      prog.push_back(aluInstr(isaPkg::ADD, 1, 1, 1));
      v = v + v;
      expectWrite(1, v);
    end
    // ADD into the sign bit sets V and N, AND to zero sets Z alone
    prog = {prog, aluInstr(isaPkg::ADD, 2, 1, 1), branchInstr(isaPkg::OVF, 1),
            llbInstr(10, m), llbInstr(4, 8'h00), aluInstr(isaPkg::AND, 3, 1, 4),
            branchInstr(isaPkg::EQ, 1), llbInstr(11, m), branchInstr(isaPkg::LT, 1),
            llbInstr(12, m), llbInstr(5, f), hltWord};
    expectWrite(2, v + v);
    expectWrite(4, 16'h0000);
    expectWrite(3, 16'h0000);
    expectWrite(5, signExt8(f));
    runAndCheck("flagEffects", halted);
    finishTest("flagEffects");
  endtask

  // Two LLBs sit behind HLT
  task automatic haltFreeze();
    logic [7:0]  a, b;
    logic [15:0] pcAtHalt;
    bit          halted;
    a = 8'($urandom());
    b = 8'($urandom());
    prog = {llbInstr(1, a), llbInstr(2, b), aluInstr(isaPkg::ADD, 3, 1, 2), hltWord,
            llbInstr(4, a), llbInstr(5, b)};
    expectWrite(1, signExt8(a));
    expectWrite(2, signExt8(b));
    expectWrite(3, signExt8(a) + signExt8(b));
    runAndCheck("haltFreeze", halted);
    if (halted) begin
      pcAtHalt = pc;
      // HLT at word 3 freezes pc on word 4
      if (pcAtHalt !== 16'd4) begin
        $display("ERR %0t: haltFreeze pc %h at halt, expected 0004", $time, pcAtHalt);
        errCount++;
      end
      repeat (haltHold) begin
        @(negedge clk);
        if (!hlt) begin
          $display("ERR %0t: haltFreeze hlt dropped", $time);
          errCount++;
        end
        if (pc !== pcAtHalt) begin
          $display("ERR %0t: haltFreeze pc moved from %h to %h", $time, pcAtHalt, pc);
          errCount++;
        end
        if (wbEn) begin
          $display("ERR %0t: haltFreeze write-back r%0d=%h after halt", $time, wbAddr, wbData);
          errCount++;
        end
      end
    end
    finishTest("haltFreeze");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstN        = 1'b0;
    imemWrEn    = 1'b0;
    imemAddr    = '0;
    imemData    = '0;
    errCount    = 0;
    failCount   = 0;
    testErrBase = 0;
    void'($urandom(32'he99344b1));
    @(negedge clk);
    arithForwarding();
    memoryLoadUse();
    branchSkips();
    flagEffects();
    haltFreeze();
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures", numTests,
             failCount, errCount, UUT.uAsserts.assertFails);
    if (errCount == 0 && UUT.uAsserts.assertFails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(numTests * cyclesPerTest * clkPeriod);
    $display("Watchdog expired after %0d cycles, run stopped", numTests * cyclesPerTest);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* sim/cpuTop_asserts.sv */
`timescale 1ns/1ps

module cpuTop_asserts (
  input logic                         clk,
  input logic                         rstN,
  input logic [isaPkg::dataWidth-1:0] pc,
  input logic                         hlt,
  input logic                         wbEn
);

  int assertFails = 0;

  // Sticky halt until reset
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else begin
      $error("hlt fell while out of reset");
      assertFails++;
    end

  pcFrozen: assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc))
    else begin
      $error("pc changed while halted");
      assertFails++;
    end

  noWbHalted: assert property (@(posedge clk) disable iff (!rstN) hlt |-> !wbEn)
    else begin
      $error("write-back strobe while halted");
      assertFails++;
    end

  // Synchronous reset clears both strobes
  resetQuiet: assert property (@(posedge clk) !rstN |=> (!wbEn && !hlt))
    else begin
      $error("wbEn or hlt set after a reset edge");
      assertFails++;
    end

endmodule

bind cpuTop cpuTop_asserts uAsserts (.clk, .rstN, .pc, .hlt, .wbEn);

/* vlog.f */
design/isaPkg.sv
design/pipePkg.sv
design/pipeIf.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/memWriteback.sv
design/cpuTop.sv
sim/cpuTop_asserts.sv
sim/cpuTb.sv
